// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int xlen        = 32;
  localparam int reg_addr_w  = 5;
  localparam int fetch_width = 4;
  localparam int imm_w       = 18;

  // anything not listed here executes as a no-op
  typedef enum logic [3:0] {
    op_add  = 4'h1,
    op_sub  = 4'h2,
    op_and  = 4'h3,
    op_or   = 4'h4,
    op_xor  = 4'h5,
    op_addi = 4'h6,
    op_ori  = 4'h7
  } op_e;

  typedef struct packed {
    op_e                   op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [12:0]           unused;
  } instr_rr_t;

  typedef struct packed {
    op_e                   op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [imm_w-1:0]      imm;
  } instr_ri_t;

  // op, rd and rs1 line up in both views
  typedef union packed {
    instr_rr_t rr;
    instr_ri_t ri;
  } instr_u;

  typedef struct packed {
    logic [xlen-1:0] pc;
    instr_u          instr;
  } ib_entry_t;

  typedef struct packed {
    logic [xlen-1:0]               pc;
    instr_u [fetch_width-1:0]      instr;
    logic [2:0]                    count;
  } fetch_grp_t;

  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc;
    op_e                   op;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       opa;
    logic [xlen-1:0]       opb;
  } issue_pkt_t;

  typedef struct packed {
    logic                  valid;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
  } fwd_t;

  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc;
    logic                  we;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
  } commit_t;

  function automatic logic writes_rd(input op_e op);
    return op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi, op_ori};
  endfunction

  // register format, rs2 is a real source
  function automatic logic is_rr(input op_e op);
    return op inside {op_add, op_sub, op_and, op_or, op_xor};
  endfunction

endpackage

`default_nettype wire

// File: source/instr_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module instr_buffer #(
  parameter int ib_depth = 8
) (
  input  wire                          aclk,
  input  wire                          rst_n,
  input  wire core_pkg::fetch_grp_t    fetch_grp,
  input  wire [1:0]                    pop_num,
  output core_pkg::ib_entry_t          head0,
  output core_pkg::ib_entry_t          head1,
  output logic [$clog2(ib_depth):0]    occupancy,
  output logic [$clog2(ib_depth):0]    free_slots
);

  localparam int ptr_w = $clog2(ib_depth);
  localparam int cnt_w = ptr_w + 1;

  core_pkg::ib_entry_t mem [ib_depth];

  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [cnt_w-1:0] count;

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + ptr_w'(pop_num);
      tail  <= tail + ptr_w'(fetch_grp.count);
      count <= count + cnt_w'(fetch_grp.count) - cnt_w'(pop_num);
    end
  end

  // slot i of the group lands at tail + i with pc base + 4i
  always_ff @(posedge aclk) begin
    for (int i = 0; i < core_pkg::fetch_width; i++) begin
      if (3'(i) < fetch_grp.count) begin
        mem[tail + ptr_w'(i)] <= '{
          pc:    fetch_grp.pc + core_pkg::xlen'(4 * i),
          instr: fetch_grp.instr[i]
        };
      end
    end
  end

  assign head0      = mem[head];
  assign head1      = mem[head + ptr_w'(1)];
  assign occupancy  = count;
  assign free_slots = cnt_w'(ib_depth) - count;

  // fetch side must respect the free slot level
  assert property (@(posedge aclk) disable iff (!rst_n)
    cnt_w'(fetch_grp.count) <= free_slots);

  // issue never pops more than is held
  assert property (@(posedge aclk) disable iff (!rst_n)
    cnt_w'(pop_num) <= occupancy);

endmodule

`default_nettype wire

// File: source/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage #(
  parameter int ib_depth = 8
) (
  input  wire                                          aclk,
  input  wire                                          rst_n,
  input  wire core_pkg::ib_entry_t                     head0,
  input  wire core_pkg::ib_entry_t                     head1,
  input  wire [$clog2(ib_depth):0]                     occupancy,
  output logic [1:0]                                   pop_num,
  output logic [3:0][core_pkg::reg_addr_w-1:0]         rf_raddr,
  input  wire [3:0][core_pkg::xlen-1:0]                rf_rdata,
  input  wire core_pkg::fwd_t                          ex_fwd0,
  input  wire core_pkg::fwd_t                          ex_fwd1,
  input  wire core_pkg::commit_t                       wb0,
  input  wire core_pkg::commit_t                       wb1,
  output core_pkg::issue_pkt_t                         pkt0,
  output core_pkg::issue_pkt_t                         pkt1
);

  logic                         v0;
  logic                         v1;
  logic                         wr0;
  logic                         hazard;
  logic                         issue1;
  logic [3:0][core_pkg::xlen-1:0] opnd;

  function automatic core_pkg::issue_pkt_t build_pkt(
    input logic                  valid,
    input core_pkg::ib_entry_t   ent,
    input logic [core_pkg::xlen-1:0] a,
    input logic [core_pkg::xlen-1:0] rs2_val
  );
    core_pkg::issue_pkt_t p;
    p.valid = valid;
    p.pc    = ent.pc;
    p.op    = ent.instr.rr.op;
    p.rd    = ent.instr.rr.rd;
    p.opa   = a;
    case (ent.instr.ri.op)
      core_pkg::op_addi:
        p.opb = {{(core_pkg::xlen - core_pkg::imm_w){ent.instr.ri.imm[core_pkg::imm_w-1]}},
                 ent.instr.ri.imm};
      core_pkg::op_ori:
        p.opb = {{(core_pkg::xlen - core_pkg::imm_w){1'b0}}, ent.instr.ri.imm};
      default:
        p.opb = rs2_val;
    endcase
    return p;
  endfunction

  assign v0  = (occupancy != '0);
  assign v1  = (occupancy >= 2);
  assign wr0 = core_pkg::writes_rd(head0.instr.rr.op) && (head0.instr.rr.rd != '0);

  // second slot may not read what the first one writes
  assign hazard = wr0 && ((head1.instr.rr.rs1 == head0.instr.rr.rd) ||
                          (core_pkg::is_rr(head1.instr.rr.op) &&
                           head1.instr.rr.rs2 == head0.instr.rr.rd));
  assign issue1  = v1 && !hazard;
  assign pop_num = !v0 ? 2'd0 : (issue1 ? 2'd2 : 2'd1);

  assign rf_raddr[0] = head0.instr.rr.rs1;
  assign rf_raddr[1] = head0.instr.rr.rs2;
  assign rf_raddr[2] = head1.instr.rr.rs1;
  assign rf_raddr[3] = head1.instr.rr.rs2;

  // oldest source first, younger ones override
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      opnd[k] = rf_rdata[k];
      if (wb0.valid && wb0.we && wb0.rd == rf_raddr[k]) opnd[k] = wb0.data;
      if (wb1.valid && wb1.we && wb1.rd == rf_raddr[k]) opnd[k] = wb1.data;
      if (ex_fwd0.valid && ex_fwd0.rd == rf_raddr[k]) opnd[k] = ex_fwd0.data;
      if (ex_fwd1.valid && ex_fwd1.rd == rf_raddr[k]) opnd[k] = ex_fwd1.data;
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      pkt0 <= '0;
      pkt1 <= '0;
    end else begin
      pkt0 <= build_pkt(v0, head0, opnd[0], opnd[1]);
      pkt1 <= build_pkt(issue1, head1, opnd[2], opnd[3]);
    end
  end

  // lane 1 only ever carries the younger of a pair
  assert property (@(posedge aclk) disable iff (!rst_n)
    pkt1.valid |-> pkt0.valid && (pkt1.pc == pkt0.pc + core_pkg::xlen'(4)));

endmodule

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  wire                                    aclk,
  input  wire                                    rst_n,
  input  wire [3:0][core_pkg::reg_addr_w-1:0]    raddr,
  output logic [3:0][core_pkg::xlen-1:0]         rdata,
  input  wire core_pkg::commit_t                 wr0,
  input  wire core_pkg::commit_t                 wr1
);

  // r0 has no storage
  logic [core_pkg::xlen-1:0] regs [1:31];

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr0.valid && wr0.we && wr0.rd != '0) regs[wr0.rd] <= wr0.data;
      // port 1 is younger, last write wins
      if (wr1.valid && wr1.we && wr1.rd != '0) regs[wr1.rd] <= wr1.data;
    end
  end

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      rdata[k] = (raddr[k] == '0) ? '0 : regs[raddr[k]];
    end
  end

endmodule

`default_nettype wire

// File: source/exe_lane.sv
`timescale 1ns/1ps
`default_nettype none

module exe_lane (
  input  wire                        aclk,
  input  wire                        rst_n,
  input  wire core_pkg::issue_pkt_t  pkt,
  output core_pkg::fwd_t             ex_fwd,
  output core_pkg::commit_t          commit
);

  logic [core_pkg::xlen-1:0] result;
  logic                      we;

  always_comb begin
    case (pkt.op)
      core_pkg::op_add, core_pkg::op_addi: result = pkt.opa + pkt.opb;
      core_pkg::op_sub:                    result = pkt.opa - pkt.opb;
      core_pkg::op_and:                    result = pkt.opa & pkt.opb;
      core_pkg::op_or, core_pkg::op_ori:   result = pkt.opa | pkt.opb;
      core_pkg::op_xor:                    result = pkt.opa ^ pkt.opb;
      default:                             result = '0;
    endcase
  end

  // no-ops and r0 targets still retire, just without a write
  assign we = pkt.valid && core_pkg::writes_rd(pkt.op) && (pkt.rd != '0);

  assign ex_fwd = '{valid: we, rd: pkt.rd, data: result};

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      commit <= '0;
    end else begin
      commit <= '{
        valid: pkt.valid,
        pc:    pkt.pc,
        we:    we,
        rd:    pkt.rd,
        data:  result
      };
    end
  end

endmodule

`default_nettype wire

// File: source/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top #(
  parameter int ib_depth = 8
) (
  input  wire                         aclk,
  input  wire                         rst_n,
  input  wire core_pkg::fetch_grp_t   fetch_grp,
  output logic [$clog2(ib_depth):0]   free_slots,
  output core_pkg::commit_t           commit0,
  output core_pkg::commit_t           commit1
);

  core_pkg::ib_entry_t                          head0;
  core_pkg::ib_entry_t                          head1;
  logic [$clog2(ib_depth):0]                    occupancy;
  logic [1:0]                                   pop_num;
  logic [3:0][core_pkg::reg_addr_w-1:0]         rf_raddr;
  logic [3:0][core_pkg::xlen-1:0]               rf_rdata;
  core_pkg::issue_pkt_t                         pkt0;
  core_pkg::issue_pkt_t                         pkt1;
  core_pkg::fwd_t                               ex_fwd0;
  core_pkg::fwd_t                               ex_fwd1;

  instr_buffer #(.ib_depth(ib_depth)) ib_i (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .fetch_grp  (fetch_grp),
    .pop_num    (pop_num),
    .head0      (head0),
    .head1      (head1),
    .occupancy  (occupancy),
    .free_slots (free_slots)
  );

  issue_stage #(.ib_depth(ib_depth)) issue_i (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .head0     (head0),
    .head1     (head1),
    .occupancy (occupancy),
    .pop_num   (pop_num),
    .rf_raddr  (rf_raddr),
    .rf_rdata  (rf_rdata),
    .ex_fwd0   (ex_fwd0),
    .ex_fwd1   (ex_fwd1),
    .wb0       (commit0),
    .wb1       (commit1),
    .pkt0      (pkt0),
    .pkt1      (pkt1)
  );

  regfile rf_i (
    .aclk  (aclk),
    .rst_n (rst_n),
    .raddr (rf_raddr),
    .rdata (rf_rdata),
    .wr0   (commit0),
    .wr1   (commit1)
  );

  exe_lane lane0_i (
    .aclk   (aclk),
    .rst_n  (rst_n),
    .pkt    (pkt0),
    .ex_fwd (ex_fwd0),
    .commit (commit0)
  );

  exe_lane lane1_i (
    .aclk   (aclk),
    .rst_n  (rst_n),
    .pkt    (pkt1),
    .ex_fwd (ex_fwd1),
    .commit (commit1)
  );

endmodule

`default_nettype wire

// File: test/tb_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;

  localparam int ib_depth   = 8;
  localparam int n_total    = 620;
  localparam int max_cycles = 4 * n_total + 200;
  localparam logic [$clog2(ib_depth):0] all_free = ib_depth;

  logic                      aclk;
  logic                      rst_n;
  core_pkg::fetch_grp_t      fetch_grp;
  logic [$clog2(ib_depth):0] free_slots;
  core_pkg::commit_t         commit0;
  core_pkg::commit_t         commit1;

  core_pkg::commit_t         exp_q[$];
  core_pkg::instr_u          prog[logic [31:0]];
  logic [31:0]               model_rf[32];
  logic [31:0]               next_pc;
  logic [4:0]                last_rd;
  int                        gen_idx;
  int                        err_cnt;
  int                        n_pass;
  int                        n_fail;
  int                        cycles;

  core_top #(.ib_depth(ib_depth)) dut_i (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .fetch_grp  (fetch_grp),
    .free_slots (free_slots),
    .commit0    (commit0),
    .commit1    (commit1)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  function automatic core_pkg::instr_u gen_instr(input int mode);
    core_pkg::instr_u w;
    w = core_pkg::instr_u'($urandom);
    w.rr.op  = core_pkg::op_e'(4'($urandom_range(0, 9)));
    w.rr.rd  = 5'($urandom_range(0, 7));
    w.rr.rs1 = 5'($urandom_range(0, 7));
    w.rr.rs2 = 5'($urandom_range(0, 7));
    case (mode)
      // each one reads the previous destination
      1: begin
        w.rr.op  = core_pkg::op_e'(4'($urandom_range(1, 7)));
        w.rr.rs1 = last_rd;
        w.rr.rd  = 5'($urandom_range(1, 7));
      end
      // r0 targets and no-ops, with r0 readers in between
      2: begin
        if (gen_idx % 2 == 1) begin
          w.rr.op  = core_pkg::op_e'(4'($urandom_range(1, 7)));
          w.rr.rd  = 5'($urandom_range(1, 7));
          w.rr.rs1 = '0;
        end else if ($urandom_range(0, 1) == 1) begin
          w.rr.rd = '0;
        end else begin
          w.rr.op = core_pkg::op_e'(4'($urandom_range(8, 15)));
        end
      end
      // all write r5, only some read it back
      3: begin
        w.rr.op  = core_pkg::op_e'(4'($urandom_range(1, 7)));
        w.rr.rd  = 5'd5;
        w.rr.rs1 = ($urandom_range(0, 3) == 0) ? 5'd5 : 5'($urandom_range(1, 4));
        w.rr.rs2 = 5'($urandom_range(1, 4));
      end
      default: ;
    endcase
    last_rd = w.rr.rd;
    gen_idx++;
    return w;
  endfunction

  // in-order reference, one instruction at a time
  function automatic core_pkg::commit_t model_step(input logic [31:0] pc,
                                                   input core_pkg::instr_u w);
    core_pkg::commit_t c;
    logic [31:0]       a;
    logic [31:0]       b;
    a = model_rf[w.rr.rs1];
    b = model_rf[w.rr.rs2];
    c = '{valid: 1'b1, pc: pc, we: 1'b1, rd: w.rr.rd, data: '0};
    case (w.rr.op)
      core_pkg::op_add:  c.data = a + b;
      core_pkg::op_sub:  c.data = a - b;
      core_pkg::op_and:  c.data = a & b;
      core_pkg::op_or:   c.data = a | b;
      core_pkg::op_xor:  c.data = a ^ b;
      core_pkg::op_addi: c.data = a + {{14{w.ri.imm[17]}}, w.ri.imm};
      core_pkg::op_ori:  c.data = a | {14'h0, w.ri.imm};
      default:           c.we = 1'b0;
    endcase
    if (w.rr.rd == '0) c.we = 1'b0;
    if (c.we) model_rf[c.rd] = c.data;
    return c;
  endfunction

  task automatic show_mismatch(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("[ERROR] %s got %h expected %h", sig, got, exp);
    err_cnt++;
  endtask

  task automatic check_commit(input string name, input core_pkg::commit_t got,
                              input core_pkg::commit_t exp);
    if (got.pc !== exp.pc) show_mismatch({name, ".pc"}, got.pc, exp.pc);
    if (got.we !== exp.we) show_mismatch({name, ".we"}, 32'(got.we), 32'(exp.we));
    if (got.rd !== exp.rd) show_mismatch({name, ".rd"}, 32'(got.rd), 32'(exp.rd));
    if (exp.we && got.data !== exp.data) show_mismatch({name, ".data"}, got.data, exp.data);
  endtask

  task automatic check_slots(input logic [$clog2(ib_depth):0] got,
                             input logic [$clog2(ib_depth):0] exp);
    if (got !== exp) show_mismatch("free_slots", 32'(got), 32'(exp));
  endtask

  task automatic check_pair(input core_pkg::commit_t c0, input core_pkg::commit_t c1);
    core_pkg::instr_u w;
    logic             rr_src;
    if (!c0.valid) begin
      $display("lane 1 retired pc %h while lane 0 was idle", c1.pc);
      err_cnt++;
    end else if (c1.pc != c0.pc + 32'd4) begin
      show_mismatch("commit1.pc", c1.pc, c0.pc + 32'd4);
    end else begin
      w = prog[c1.pc];
      rr_src = w.rr.op inside {core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
                               core_pkg::op_or, core_pkg::op_xor};
      if (c0.we && (w.rr.rs1 == c0.rd || (rr_src && w.rr.rs2 == c0.rd))) begin
        $display("pc %h issued beside its producer at pc %h", c1.pc, c0.pc);
        err_cnt++;
      end
    end
  endtask

  task automatic take_commit(input string name, input core_pkg::commit_t c);
    if (exp_q.size() == 0) begin
      $display("%s retired pc %h with nothing left in the model queue", name, c.pc);
      err_cnt++;
    end else begin
      check_commit(name, c, exp_q.pop_front());
    end
  endtask

  // outputs are sampled half a cycle away from the edge that changes them
  always @(negedge aclk) begin
    if (rst_n) begin
      if (commit1.valid) check_pair(commit0, commit1);
      if (commit0.valid) take_commit("commit0", commit0);
      if (commit1.valid) take_commit("commit1", commit1);
    end
  end

  task automatic push_group(input int mode, inout int left);
    core_pkg::fetch_grp_t g;
    int                   n;
    @(posedge aclk);
    #1;
    n = (mode == 4) ? 4 : $urandom_range(0, 4);
    if (n > int'(free_slots)) n = int'(free_slots);
    if (n > left) n = left;
    g.pc    = next_pc;
    g.count = 3'(n);
    for (int i = 0; i < 4; i++) begin
      if (i < n) begin
        g.instr[i]    = gen_instr(mode);
        prog[next_pc] = g.instr[i];
        exp_q.push_back(model_step(next_pc, g.instr[i]));
        next_pc += 32'd4;
      end else begin
        g.instr[i] = core_pkg::instr_u'($urandom);
      end
    end
    fetch_grp = g;
    left -= n;
  endtask

  task automatic run_test(input string name, input int mode, input int n);
    int left;
    int errs0;
    left  = n;
    errs0 = err_cnt;
    while (left > 0) push_group(mode, left);
    @(posedge aclk);
    #1;
    fetch_grp.count = '0;
    while (exp_q.size() != 0) @(posedge aclk);
    #1;
    // everything retired, so the buffer is empty again
    check_slots(free_slots, all_free);
    if (err_cnt == errs0) n_pass++;
    else n_fail++;
    $display("%-12s %0d instructions, %0d errors", name, n, err_cnt - errs0);
  endtask

  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge aclk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d commits never arrived", max_cycles, exp_q.size());
    $display("Test FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hfb83_5103));
    rst_n     = 1'b0;
    fetch_grp = '0;
    next_pc   = 32'h0000_1000;
    last_rd   = 5'd1;
    gen_idx   = 0;
    err_cnt   = 0;
    n_pass    = 0;
    n_fail    = 0;
    for (int i = 0; i < 32; i++) model_rf[i] = '0;
    repeat (2) @(posedge aclk);
    #1;
    rst_n = 1'b1;
    check_slots(free_slots, all_free);
    run_test("random_mix", 0, 300);
    run_test("dep_chain", 1, 80);
    run_test("r0_noop", 2, 60);
    run_test("same_dest", 3, 60);
    run_test("full_burst", 4, 120);
    // catch stray commits after the last drain
    repeat (4) @(posedge aclk);
    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, err_cnt);
    if (n_fail == 0 && err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
source/core_pkg.sv
source/instr_buffer.sv
source/issue_stage.sv
source/regfile.sv
source/exe_lane.sv
source/core_top.sv
test/tb_core_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
